// ==== Makefile ====
SOURCES = project.f $(wildcard verilog/*.sv verilog/*.svh verification/*.sv verification/*.svh)

all: run

obj_dir/Vcpu_tb: $(SOURCES)
	verilator --binary --timing -f project.f --top-module cpu_tb

run: obj_dir/Vcpu_tb
	./obj_dir/Vcpu_tb | tee sim.log
	grep -qx "Test OK" sim.log

lint:
	verilator --lint-only --timing -f project.f --top-module cpu_tb

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

// ==== project.f ====
+incdir+verilog
+incdir+verification
verilog/cpu_pkg.sv
verilog/cpu_alu.sv
verilog/register_file.sv
verilog/opcode_decoder.sv
verilog/cpu_sequencer.sv
verilog/cpu_core.sv
verification/cpu_tb.sv

// ==== verification/cpu_tb_program.svh ====
// program builder and reference model for the cpu testbench
// xorshift random source, a random program of kept and unknown opcodes
// behind the reset vector, and an instruction level model that predicts
// the read addresses, the bus writes, the skipped code bytes and the final flags

`ifndef CPU_TB_PROGRAM_SVH
`define CPU_TB_PROGRAM_SVH

localparam int K_LOAD = 0;
localparam int K_ADD  = 1;
localparam int K_SUB  = 2;
localparam int K_AND  = 3;
localparam int K_EOR  = 4;

logic [31:0] rng_state;
logic [15:0] build_pc;
logic [15:0] program_start;
logic [15:0] program_end; // address of the final jump to itself
logic [7:0]  m_a;
logic [7:0]  m_b;
logic        m_n;
logic        m_z;
logic        m_v;
logic        m_c;

function automatic logic [31:0] rand32();
	logic [31:0] x;
	x = rng_state;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	rng_state = x;
	return x;
endfunction

function automatic logic is_kept(input logic [7:0] op);
	case (op)
		`OPC_LDA_IMM, `OPC_LDA_EXT, `OPC_LDB_IMM, `OPC_LDB_EXT,
		`OPC_ADDA_IMM, `OPC_ADDB_IMM, `OPC_SUBA_IMM, `OPC_ANDA_IMM, `OPC_EORA_IMM,
		`OPC_STA_EXT, `OPC_STB_EXT, `OPC_JMP_EXT, `OPC_BRA, `OPC_BNE, `OPC_BEQ:
			return 1'b1;
		default:
			return 1'b0;
	endcase
endfunction

function automatic logic [7:0] unknown_op();
	logic [31:0] r;
	logic [7:0]  op;
	do
	begin
		r = rand32();
		op = r[7:0];
	end
	while (is_kept(op));
	return op;
endfunction

task automatic emit(input logic [7:0] b);
	mem[build_pc] = b;
	build_pc = build_pc + 16'd1;
endtask

task automatic build_program();
	logic [31:0] r;
	logic [15:0] a;
	logic [7:0]  op;
	logic [1:0]  kind; // 0 inherent, 1 immediate, 2 extended, 3 branch
	logic [2:0]  skip;
	a = 16'd0;
	do
	begin
		mem[a] = a[15:8] ^ {a[6:0], a[7]};
		skipped[a] = 1'b0;
		a = a + 16'd1;
	end
	while (a != 16'd0);
	a = 16'h8000; // data region for extended loads and stores
	do
	begin
		r = rand32();
		mem[a] = r[7:0];
		a = a + 16'd1;
	end
	while (a != 16'h8100);
	r = rand32();
	program_start = 16'h1000 + {4'h0, r[11:0]};
	mem[`CPU_RESET_VECTOR] = program_start[15:8];
	mem[`CPU_RESET_VECTOR + 16'd1] = program_start[7:0];
	build_pc = program_start;
	repeat (40)
	begin
		r = rand32();
		case (r[3:0])
			4'd0:    op = `OPC_LDA_IMM;
			4'd1:    op = `OPC_LDB_IMM;
			4'd2:    op = `OPC_LDA_EXT;
			4'd3:    op = `OPC_LDB_EXT;
			4'd4:    op = `OPC_ADDA_IMM;
			4'd5:    op = `OPC_ADDB_IMM;
			4'd6:    op = `OPC_SUBA_IMM;
			4'd7:    op = `OPC_ANDA_IMM;
			4'd8:    op = `OPC_EORA_IMM;
			4'd9:    op = `OPC_STA_EXT;
			4'd10:   op = `OPC_STB_EXT;
			4'd11:   op = `OPC_STA_EXT;
			4'd12:   op = `OPC_BEQ;
			4'd13:   op = `OPC_BNE;
			4'd14:   op = `OPC_BRA;
			default: op = unknown_op();
		endcase
		case (op)
			`OPC_LDA_EXT, `OPC_LDB_EXT, `OPC_STA_EXT, `OPC_STB_EXT: kind = 2'd2;
			`OPC_BRA, `OPC_BEQ, `OPC_BNE:                           kind = 2'd3;
			default:
				kind = is_kept(op) ? 2'd1 : 2'd0;
		endcase
		emit(op);
		case (kind)
			2'd1: emit(r[15:8]);
			2'd2:
			begin
				emit(8'h80);
				emit(r[23:16]);
			end
			2'd3:
			begin
				skip = 3'(r[31:24] % 8'd5); // forward skip of 0 to 4 bytes
				emit({5'd0, skip});
				repeat (skip) emit(unknown_op());
			end
			default: ;
		endcase
	end
	program_end = build_pc;
	emit(`OPC_JMP_EXT);
	emit(program_end[15:8]);
	emit(program_end[7:0]);
endtask

task automatic model_alu(input int kind, inout logic [7:0] acc, input logic [7:0] opnd);
	int         wide;
	int         swide;
	logic [7:0] res;
	case (kind)
		K_ADD:
		begin
			wide = int'(acc) + int'(opnd);
			swide = int'($signed(acc)) + int'($signed(opnd));
			m_c = (wide > 255);
			m_v = (swide > 127) || (swide < -128);
		end
		K_SUB:
		begin
			wide = int'(acc) - int'(opnd);
			swide = int'($signed(acc)) - int'($signed(opnd));
			m_c = (wide < 0); // borrow
			m_v = (swide > 127) || (swide < -128);
		end
		K_AND:
		begin
			wide = int'(acc & opnd);
			m_v = 1'b0;
		end
		K_EOR:
		begin
			wide = int'(acc ^ opnd);
			m_v = 1'b0;
		end
		default:
		begin
			wide = int'(opnd);
			m_v = 1'b0;
		end
	endcase
	res = 8'(wide);
	m_n = res[7];
	m_z = (res == 8'h00);
	acc = res;
endtask

task automatic store_byte(input logic [15:0] ea, input logic [7:0] value);
	ref_mem[ea] = value;
	exp_waddr.push_back(ea);
	exp_wdata.push_back(value);
endtask

task automatic run_model();
	logic [15:0] a;
	logic [15:0] pc;
	logic [15:0] ea;
	logic [7:0]  op;
	logic [7:0]  opnd;
	int          steps;
	a = 16'd0;
	do
	begin
		ref_mem[a] = mem[a];
		a = a + 16'd1;
	end
	while (a != 16'd0);
	m_a = 8'h00;
	m_b = 8'h00;
	m_n = 1'b0;
	m_z = 1'b0;
	m_v = 1'b0;
	m_c = 1'b0;
	pc = program_start;
	steps = 0;
	while (pc != program_end && steps < 1000)
	begin
		op = ref_mem[pc];
		exp_raddr.push_back(pc);
		pc = pc + 16'd1;
		opnd = 8'h00;
		ea = 16'h0000;
		case (op)
			`OPC_LDA_EXT, `OPC_LDB_EXT, `OPC_STA_EXT, `OPC_STB_EXT, `OPC_JMP_EXT:
			begin
				exp_raddr.push_back(pc);
				exp_raddr.push_back(pc + 16'd1);
				ea = {ref_mem[pc], ref_mem[pc + 16'd1]};
				pc = pc + 16'd2;
				opnd = ref_mem[ea];
				if (op == `OPC_LDA_EXT || op == `OPC_LDB_EXT) // data byte read
					exp_raddr.push_back(ea);
			end
			default:
			begin
				if (is_kept(op)) // immediate byte or branch offset
				begin
					exp_raddr.push_back(pc);
					opnd = ref_mem[pc];
					pc = pc + 16'd1;
				end
			end
		endcase
		case (op)
			`OPC_LDA_IMM, `OPC_LDA_EXT: model_alu(K_LOAD, m_a, opnd);
			`OPC_LDB_IMM, `OPC_LDB_EXT: model_alu(K_LOAD, m_b, opnd);
			`OPC_ADDA_IMM:              model_alu(K_ADD, m_a, opnd);
			`OPC_ADDB_IMM:              model_alu(K_ADD, m_b, opnd);
			`OPC_SUBA_IMM:              model_alu(K_SUB, m_a, opnd);
			`OPC_ANDA_IMM:              model_alu(K_AND, m_a, opnd);
			`OPC_EORA_IMM:              model_alu(K_EOR, m_a, opnd);
			`OPC_STA_EXT:               store_byte(ea, m_a);
			`OPC_STB_EXT:               store_byte(ea, m_b);
			`OPC_JMP_EXT:               pc = ea;
			`OPC_BRA, `OPC_BEQ, `OPC_BNE:
			begin
				if ((op == `OPC_BRA) || (op == `OPC_BEQ && m_z) || (op == `OPC_BNE && !m_z))
				begin
					repeat (opnd)
					begin
						skipped[pc] = 1'b1;
						pc = pc + 16'd1;
					end
				end
			end
			default: ; // unknown opcode takes one byte
		endcase
		steps++;
	end
	exp_raddr.push_back(pc); // first fetch of the final jump
	exp_cc = {m_n, m_z, m_v, m_c};
endtask

`endif

// ==== verification/cpu_tb.sv ====
// testbench for the cpu core
// runs a random program against an instruction level model and checks
// the reset vector fetch, the read order, the bus writes, branch skips
// and final flags

`timescale 1ns/1ps

`include "cpu_cfg.svh"

module cpu_tb;

	logic                   cpu_clk;
	logic                   k_reset;
	logic [`CPU_DATA_W-1:0] cpu_data_i = '0;
	logic [`CPU_ADDR_W-1:0] cpu_addr_o;
	logic [`CPU_DATA_W-1:0] cpu_data_o;
	logic                   cpu_oe_o;
	logic                   cpu_we_o;
	cpu_pkg::cc_flags_t     cpu_cc_o;

	logic [7:0]  mem [0:65535];
	logic [7:0]  ref_mem [0:65535];
	logic        skipped [0:65535]; // code bytes jumped over by taken branches
	logic [15:0] exp_waddr [$];
	logic [7:0]  exp_wdata [$];
	logic [15:0] exp_raddr [$]; // reads from the first fetch on
	logic [15:0] read_log [$];
	logic [3:0]  exp_cc;
	int          write_count = 0;
	int          end_hits = 0;
	int          bus_errors = 0;
	int          skip_errors = 0;
	int          tests = 0;
	int          checks = 0;
	int          errors = 0;

	`include "cpu_tb_program.svh"

	cpu_core i_cpu_core (
		.cpu_clk(cpu_clk),
		.k_reset(k_reset),
		.cpu_data_i(cpu_data_i),
		.cpu_addr_o(cpu_addr_o),
		.cpu_data_o(cpu_data_o),
		.cpu_oe_o(cpu_oe_o),
		.cpu_we_o(cpu_we_o),
		.cpu_cc_o(cpu_cc_o)
	);

	initial
	begin
		cpu_clk = 1'b0;
		forever #2 cpu_clk = ~cpu_clk;
	end

	task automatic check_write();
		checks++;
		if (write_count >= exp_waddr.size())
		begin
			$display("unexpected write of %h to %h", cpu_data_o, cpu_addr_o);
			bus_errors++;
		end
		else
		begin
			if (cpu_addr_o !== exp_waddr[write_count])
			begin
				$display("CHECK FAILED cpu_addr_o expected %h got %h",
					exp_waddr[write_count], cpu_addr_o);
				bus_errors++;
			end
			if (cpu_data_o !== exp_wdata[write_count])
			begin
				$display("CHECK FAILED cpu_data_o expected %h got %h",
					exp_wdata[write_count], cpu_data_o);
				bus_errors++;
			end
		end
		write_count++;
	endtask

	// memory model and bus monitor
	always @(posedge cpu_clk)
	begin
		if (cpu_oe_o)
		begin
			cpu_data_i <= mem[cpu_addr_o];
			read_log.push_back(cpu_addr_o);
			if (cpu_addr_o == program_end)
				end_hits++;
			if (skipped[cpu_addr_o])
			begin
				$display("read strobe at skipped code byte %h", cpu_addr_o);
				skip_errors++;
			end
		end
		if (cpu_we_o)
		begin
			mem[cpu_addr_o] = cpu_data_o;
			check_write();
		end
	end

	task automatic report_test(input string name, input int fails);
		tests++;
		errors += fails;
		if (fails == 0)
			$display("%s: passed", name);
		else
			$display("%s: failed with %0d error(s)", name, fails);
	endtask

	initial
	begin
		int cycles;
		int fails;
		int idx;
		k_reset = 1'b1;
		rng_state = 32'hd572_9860;
		build_program();
		run_model();
		fails = 0;
		repeat (8)
		begin
			@(posedge cpu_clk);
			checks++;
			if (cpu_oe_o || cpu_we_o)
			begin
				$display("a bus strobe is active while k_reset is high");
				fails++;
			end
		end
		k_reset <= 1'b0;
		cycles = 0;
		while (read_log.size() < 3 && cycles < 50)
		begin
			@(negedge cpu_clk);
			cycles++;
		end
		if (read_log.size() < 3)
		begin
			$display("timed out waiting for the reset vector reads");
			fails++;
		end
		else
		begin
			checks += 2;
			if (read_log[0] !== `CPU_RESET_VECTOR)
			begin
				$display("CHECK FAILED cpu_addr_o expected %h got %h", `CPU_RESET_VECTOR, read_log[0]);
				fails++;
			end
			if (read_log[1] !== `CPU_RESET_VECTOR + 16'd1)
			begin
				$display("CHECK FAILED cpu_addr_o expected %h got %h", `CPU_RESET_VECTOR + 16'd1,
					read_log[1]);
				fails++;
			end
		end
		report_test("reset and vector reads", fails);
		fails = 0;
		checks++;
		if (read_log.size() < 3)
		begin
			$display("no read strobe for the first opcode fetch");
			fails++;
		end
		else if (read_log[2] !== program_start)
		begin
			$display("CHECK FAILED cpu_addr_o expected %h got %h", program_start, read_log[2]);
			fails++;
		end
		report_test("first fetch at vector", fails);
		fails = 0;
		cycles = 0;
		while (end_hits < 2 && cycles < 5000) // second fetch proves the final jump loops
		begin
			@(negedge cpu_clk);
			cycles++;
		end
		if (end_hits < 2)
		begin
			$display("timed out waiting for the final jump loop at %h", program_end);
			fails++;
		end
		report_test("program stores", fails + bus_errors);
		report_test("branch skips", skip_errors);
		fails = 0;
		checks++;
		idx = 0;
		while (idx < exp_raddr.size() && idx + 2 < read_log.size() &&
			read_log[idx + 2] === exp_raddr[idx])
			idx++;
		if (idx < exp_raddr.size())
		begin
			if (idx + 2 >= read_log.size())
				$display("read strobes stopped before the expected read at %h", exp_raddr[idx]);
			else
				$display("CHECK FAILED cpu_addr_o expected %h got %h", exp_raddr[idx],
					read_log[idx + 2]);
			fails++;
		end
		report_test("read order", fails);
		fails = 0;
		checks++;
		if (write_count != exp_waddr.size())
		begin
			$display("CHECK FAILED write_count expected %h got %h", exp_waddr.size(), write_count);
			fails++;
		end
		report_test("write count", fails);
		fails = 0;
		checks++;
		if (cpu_cc_o !== exp_cc)
		begin
			$display("CHECK FAILED cpu_cc_o expected %h got %h", exp_cc, cpu_cc_o);
			fails++;
		end
		report_test("final flags", fails);
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== verilog/cpu_alu.sv ====
// cpu alu
// 8-bit load, add, subtract, and, exclusive or and pass operations
// on an accumulator and an operand byte, with the new N, Z, V and C flags

`timescale 1ns/1ps

`include "cpu_cfg.svh"

module cpu_alu (
	input  cpu_pkg::alu_op_e       op_i,
	input  logic [`CPU_DATA_W-1:0] acc_i,
	input  logic [`CPU_DATA_W-1:0] operand_i,
	input  cpu_pkg::cc_flags_t     cc_i,
	output logic [`CPU_DATA_W-1:0] result_o,
	output cpu_pkg::cc_flags_t     cc_o
);
	import cpu_pkg::*;

	localparam int MSB = `CPU_DATA_W - 1;

	logic [`CPU_DATA_W:0] sum_w;  // top bit is the carry out
	logic [`CPU_DATA_W:0] diff_w; // top bit is the borrow
	logic                 update_nz;

	assign sum_w = {1'b0, acc_i} + {1'b0, operand_i};
	assign diff_w = {1'b0, acc_i} - {1'b0, operand_i};

	always_comb
	begin
		result_o = acc_i;
		cc_o = cc_i;
		update_nz = 1'b1;
		case (op_i)
			ALU_LOAD:
			begin
				result_o = operand_i;
				cc_o.v = 1'b0;
			end
			ALU_ADD:
			begin
				result_o = sum_w[MSB:0];
				cc_o.v = (acc_i[MSB] == operand_i[MSB]) && (sum_w[MSB] != acc_i[MSB]);
				cc_o.c = sum_w[`CPU_DATA_W];
			end
			ALU_SUB:
			begin
				result_o = diff_w[MSB:0];
				cc_o.v = (acc_i[MSB] != operand_i[MSB]) && (diff_w[MSB] != acc_i[MSB]);
				cc_o.c = diff_w[`CPU_DATA_W];
			end
			ALU_AND:
			begin
				result_o = acc_i & operand_i;
				cc_o.v = 1'b0;
			end
			ALU_EOR:
			begin
				result_o = acc_i ^ operand_i;
				cc_o.v = 1'b0;
			end
			default: update_nz = 1'b0; // pass, flags kept as they are
		endcase
		if (update_nz)
		begin
			cc_o.n = result_o[MSB];
			cc_o.z = (result_o == '0);
		end
	end

endmodule

// ==== verilog/cpu_cfg.svh ====
// cpu configuration
// bus widths, the cold reset vector and the 6809 opcode encodings
// of the instruction subset that the core executes

`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

`define CPU_ADDR_W        16
`define CPU_DATA_W        8

`define CPU_RESET_VECTOR  16'hFFFE // high byte here, low byte at the next address

// accumulator loads
`define OPC_LDA_IMM       8'h86
`define OPC_LDA_EXT       8'hB6
`define OPC_LDB_IMM       8'hC6
`define OPC_LDB_EXT       8'hF6

// alu operations, immediate only
`define OPC_ADDA_IMM      8'h8B
`define OPC_ADDB_IMM      8'hCB
`define OPC_SUBA_IMM      8'h80
`define OPC_ANDA_IMM      8'h84
`define OPC_EORA_IMM      8'h88

`define OPC_STA_EXT       8'hB7
`define OPC_STB_EXT       8'hF7
`define OPC_JMP_EXT       8'h7E

`define OPC_BRA           8'h20
`define OPC_BNE           8'h26
`define OPC_BEQ           8'h27

`endif

// ==== verilog/cpu_core.sv ====
// cpu core top level
// connects sequencer, opcode decoder, register file and alu
// to the single-cycle strobe memory bus

`timescale 1ns/1ps

`include "cpu_cfg.svh"

module cpu_core (
	input  logic                   cpu_clk,
	input  logic                   k_reset,
	input  logic [`CPU_DATA_W-1:0] cpu_data_i,
	output logic [`CPU_ADDR_W-1:0] cpu_addr_o,
	output logic [`CPU_DATA_W-1:0] cpu_data_o,
	output logic                   cpu_oe_o,
	output logic                   cpu_we_o,
	output cpu_pkg::cc_flags_t     cpu_cc_o
);
	import cpu_pkg::*;

	decoded_insn_t          insn;
	cc_flags_t              alu_cc;
	logic [`CPU_DATA_W-1:0] opcode;
	logic [`CPU_DATA_W-1:0] operand;
	logic [`CPU_DATA_W-1:0] acc;
	logic [`CPU_DATA_W-1:0] alu_result;
	logic [`CPU_ADDR_W-1:0] pc;
	logic [`CPU_ADDR_W-1:0] pc_target;
	logic                   pc_inc;
	logic                   pc_load;
	logic                   acc_write;
	logic                   flags_write;

	cpu_sequencer i_sequencer (
		.cpu_clk(cpu_clk),         .k_reset(k_reset),
		.cpu_data_i(cpu_data_i),   .insn_i(insn),
		.pc_i(pc),                 .acc_i(acc),
		.cc_i(cpu_cc_o),           .opcode_o(opcode),
		.operand_o(operand),       .cpu_addr_o(cpu_addr_o),
		.cpu_data_o(cpu_data_o),   .cpu_oe_o(cpu_oe_o),
		.cpu_we_o(cpu_we_o),       .pc_inc_o(pc_inc),
		.pc_load_o(pc_load),       .pc_target_o(pc_target),
		.acc_write_o(acc_write),   .flags_write_o(flags_write)
	);

	opcode_decoder i_decoder (
		.opcode_i(opcode),
		.insn_o(insn)
	);

	register_file i_regs (
		.cpu_clk(cpu_clk),         .k_reset(k_reset),
		.use_b_i(insn.use_b),      .acc_write_i(acc_write),
		.acc_data_i(alu_result),   .flags_write_i(flags_write),
		.cc_data_i(alu_cc),        .pc_inc_i(pc_inc),
		.pc_load_i(pc_load),       .pc_target_i(pc_target),
		.acc_o(acc),               .pc_o(pc),
		.cc_o(cpu_cc_o)
	);

	cpu_alu i_alu (
		.op_i(insn.alu_op),
		.acc_i(acc),
		.operand_i(operand),
		.cc_i(cpu_cc_o),
		.result_o(alu_result),
		.cc_o(alu_cc)
	);

endmodule

// ==== verilog/cpu_pkg.sv ====
// cpu package
// types shared by the core blocks: addressing modes, alu operations,
// branch conditions, condition code flags, sequencer states and the
// decoded instruction word

package cpu_pkg;

	typedef enum logic [1:0] {
		AM_INHERENT,
		AM_IMMEDIATE,
		AM_EXTENDED,
		AM_REL8
	} addr_mode_e;

	typedef enum logic [2:0] {
		ALU_LOAD,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_EOR,
		ALU_PASS // accumulator through, flags kept
	} alu_op_e;

	typedef enum logic [1:0] {
		BR_ALWAYS,
		BR_EQ,
		BR_NE
	} branch_cond_e;

	typedef struct packed {
		logic n;
		logic z;
		logic v;
		logic c;
	} cc_flags_t;

	// every bus read walks through an address, strobe and capture state
	typedef enum logic [4:0] {
		S_COLD, S_VEC_HI_OE, S_VEC_HI_CAP,
		S_VEC_LO_ADDR, S_VEC_LO_OE, S_VEC_LO_CAP, S_LOAD_PC,
		S_FETCH, S_FETCH_OE, S_FETCH_CAP, S_DECODE,
		S_OPER_ADDR, S_OPER_OE, S_OPER_CAP,
		S_EAHI_ADDR, S_EAHI_OE, S_EAHI_CAP,
		S_EALO_ADDR, S_EALO_OE, S_EALO_CAP, S_EA,
		S_MEM_ADDR, S_MEM_OE, S_MEM_CAP,
		S_EXEC, S_WBACK, S_STORE, S_JUMP, S_BRANCH
	} seq_state_e;

	typedef struct packed {
		addr_mode_e   mode;
		alu_op_e      alu_op;
		logic         use_b;     // accumulator b is the target
		logic         reads_mem; // extended load
		logic         is_store;
		logic         is_jump;
		logic         is_branch;
		branch_cond_e cond;
	} decoded_insn_t;

endpackage

// ==== verilog/cpu_sequencer.sv ====
// cpu sequencer
// control FSM of the core: reset vector fetch, opcode fetch and decode,
// operand and address byte reads, execute, writeback, store, jump and
// branch. drives the bus strobes and the register file strobes

`timescale 1ns/1ps

`include "cpu_cfg.svh"

module cpu_sequencer (
	input  logic                   cpu_clk,
	input  logic                   k_reset,
	input  logic [`CPU_DATA_W-1:0] cpu_data_i,
	input  cpu_pkg::decoded_insn_t insn_i,
	input  logic [`CPU_ADDR_W-1:0] pc_i,
	input  logic [`CPU_DATA_W-1:0] acc_i,
	input  cpu_pkg::cc_flags_t     cc_i,
	output logic [`CPU_DATA_W-1:0] opcode_o,
	output logic [`CPU_DATA_W-1:0] operand_o,
	output logic [`CPU_ADDR_W-1:0] cpu_addr_o,
	output logic [`CPU_DATA_W-1:0] cpu_data_o,
	output logic                   cpu_oe_o,
	output logic                   cpu_we_o,
	output logic                   pc_inc_o,
	output logic                   pc_load_o,
	output logic [`CPU_ADDR_W-1:0] pc_target_o,
	output logic                   acc_write_o,
	output logic                   flags_write_o
);
	import cpu_pkg::*;

	seq_state_e             state;
	logic [`CPU_DATA_W-1:0] opcode_q;
	logic [`CPU_DATA_W-1:0] operand_q; // also low byte of vector and jump address
	logic [`CPU_ADDR_W-1:0] ea_q;
	logic [`CPU_ADDR_W-1:0] addr_q;
	logic [`CPU_DATA_W-1:0] data_q;
	logic                   acc_write_q;
	logic                   flags_write_q;
	logic                   branch_taken;
	logic [`CPU_ADDR_W-1:0] branch_target;

	always_comb
	begin
		case (insn_i.cond)
			BR_EQ:   branch_taken = cc_i.z;
			BR_NE:   branch_taken = !cc_i.z;
			default: branch_taken = 1'b1;
		endcase
	end

	// pc already points past the offset byte here
	assign branch_target = pc_i +
		{{(`CPU_ADDR_W-`CPU_DATA_W){operand_q[`CPU_DATA_W-1]}}, operand_q};

	always_ff @(posedge cpu_clk or posedge k_reset)
	begin
		if (k_reset)
		begin
			state <= S_COLD;
			acc_write_q <= 1'b0;
			flags_write_q <= 1'b0;
		end
		else
		begin
			acc_write_q <= 1'b0; // single cycle strobes
			flags_write_q <= 1'b0;
			case (state)
				S_COLD:        state <= S_VEC_HI_OE;
				S_VEC_HI_OE:   state <= S_VEC_HI_CAP;
				S_VEC_HI_CAP:  state <= S_VEC_LO_ADDR;
				S_VEC_LO_ADDR: state <= S_VEC_LO_OE;
				S_VEC_LO_OE:   state <= S_VEC_LO_CAP;
				S_VEC_LO_CAP:  state <= S_LOAD_PC;
				S_LOAD_PC:     state <= S_FETCH;
				S_FETCH:       state <= S_FETCH_OE;
				S_FETCH_OE:    state <= S_FETCH_CAP;
				S_FETCH_CAP:   state <= S_DECODE;
				S_DECODE:
				begin
					case (insn_i.mode)
						AM_IMMEDIATE, AM_REL8: state <= S_OPER_ADDR;
						AM_EXTENDED:           state <= S_EAHI_ADDR;
						default:               state <= S_FETCH; // unknown opcodes end here
					endcase
				end
				S_OPER_ADDR:   state <= S_OPER_OE;
				S_OPER_OE:     state <= S_OPER_CAP;
				S_OPER_CAP:    state <= insn_i.is_branch ? S_BRANCH : S_EXEC;
				S_EAHI_ADDR:   state <= S_EAHI_OE;
				S_EAHI_OE:     state <= S_EAHI_CAP;
				S_EAHI_CAP:    state <= S_EALO_ADDR;
				S_EALO_ADDR:   state <= S_EALO_OE;
				S_EALO_OE:     state <= S_EALO_CAP;
				S_EALO_CAP:    state <= insn_i.is_jump ? S_JUMP : S_EA;
				S_EA:          state <= insn_i.reads_mem ? S_MEM_ADDR : S_EXEC;
				S_MEM_ADDR:    state <= S_MEM_OE;
				S_MEM_OE:      state <= S_MEM_CAP;
				S_MEM_CAP:     state <= S_EXEC;
				S_EXEC:
				begin
					if (insn_i.is_store)
						state <= S_STORE;
					else
					begin
						state <= S_WBACK;
						acc_write_q <= (insn_i.alu_op != ALU_PASS);
						flags_write_q <= 1'b1;
					end
				end
				S_STORE:       state <= S_WBACK; // address and data held one more cycle
				default:       state <= S_FETCH; // wback, jump, branch
			endcase
		end
	end

	always_ff @(posedge cpu_clk)
	begin
		case (state)
			S_COLD:        addr_q <= `CPU_RESET_VECTOR;
			S_VEC_LO_ADDR: addr_q <= addr_q + 1'b1;
			S_FETCH, S_OPER_ADDR, S_EAHI_ADDR, S_EALO_ADDR:
				addr_q <= pc_i;
			S_FETCH_CAP:   opcode_q <= cpu_data_i;
			S_VEC_HI_CAP, S_EAHI_CAP:
				ea_q[`CPU_ADDR_W-1:`CPU_DATA_W] <= cpu_data_i;
			S_VEC_LO_CAP, S_OPER_CAP, S_EALO_CAP, S_MEM_CAP:
				operand_q <= cpu_data_i;
			S_EA:          ea_q[`CPU_DATA_W-1:0] <= operand_q;
			S_MEM_ADDR:    addr_q <= ea_q;
			S_EXEC:
			begin
				if (insn_i.is_store)
				begin
					addr_q <= ea_q;
					data_q <= acc_i;
				end
			end
			default: ;
		endcase
	end

	assign cpu_oe_o = state inside {S_VEC_HI_OE, S_VEC_LO_OE, S_FETCH_OE, S_OPER_OE,
		S_EAHI_OE, S_EALO_OE, S_MEM_OE};
	assign cpu_we_o = (state == S_STORE);
	assign cpu_addr_o = addr_q;
	assign cpu_data_o = data_q;

	assign pc_inc_o = state inside {S_FETCH, S_OPER_ADDR, S_EAHI_ADDR, S_EALO_ADDR};
	assign pc_load_o = (state == S_LOAD_PC) || (state == S_JUMP) ||
		((state == S_BRANCH) && branch_taken);
	assign pc_target_o = (state == S_BRANCH) ? branch_target :
		{ea_q[`CPU_ADDR_W-1:`CPU_DATA_W], operand_q}; // vector or jump address

	assign acc_write_o = acc_write_q;
	assign flags_write_o = flags_write_q;
	assign opcode_o = opcode_q;
	assign operand_o = operand_q;

endmodule

// ==== verilog/opcode_decoder.sv ====
// opcode decoder
// turns the fetched opcode byte into the decoded instruction word,
// unknown opcodes come out as an inherent no-op

`timescale 1ns/1ps

`include "cpu_cfg.svh"

module opcode_decoder (
	input  logic [`CPU_DATA_W-1:0] opcode_i,
	output cpu_pkg::decoded_insn_t insn_o
);
	import cpu_pkg::*;

	always_comb
	begin
		insn_o.mode = AM_INHERENT;
		insn_o.alu_op = ALU_PASS;
		insn_o.use_b = 1'b0;
		insn_o.reads_mem = 1'b0;
		insn_o.is_store = 1'b0;
		insn_o.is_jump = 1'b0;
		insn_o.is_branch = 1'b0;
		insn_o.cond = BR_ALWAYS;
		case (opcode_i)
			`OPC_LDA_IMM, `OPC_LDB_IMM:
			begin
				insn_o.mode = AM_IMMEDIATE;
				insn_o.alu_op = ALU_LOAD;
				insn_o.use_b = (opcode_i == `OPC_LDB_IMM);
			end
			`OPC_LDA_EXT, `OPC_LDB_EXT:
			begin
				insn_o.mode = AM_EXTENDED;
				insn_o.alu_op = ALU_LOAD;
				insn_o.use_b = (opcode_i == `OPC_LDB_EXT);
				insn_o.reads_mem = 1'b1;
			end
			`OPC_ADDA_IMM, `OPC_ADDB_IMM:
			begin
				insn_o.mode = AM_IMMEDIATE;
				insn_o.alu_op = ALU_ADD;
				insn_o.use_b = (opcode_i == `OPC_ADDB_IMM);
			end
			`OPC_SUBA_IMM:
			begin
				insn_o.mode = AM_IMMEDIATE;
				insn_o.alu_op = ALU_SUB;
			end
			`OPC_ANDA_IMM:
			begin
				insn_o.mode = AM_IMMEDIATE;
				insn_o.alu_op = ALU_AND;
			end
			`OPC_EORA_IMM:
			begin
				insn_o.mode = AM_IMMEDIATE;
				insn_o.alu_op = ALU_EOR;
			end
			`OPC_STA_EXT, `OPC_STB_EXT:
			begin
				insn_o.mode = AM_EXTENDED; // alu stays on pass
				insn_o.use_b = (opcode_i == `OPC_STB_EXT);
				insn_o.is_store = 1'b1;
			end
			`OPC_JMP_EXT:
			begin
				insn_o.mode = AM_EXTENDED;
				insn_o.is_jump = 1'b1;
			end
			`OPC_BRA, `OPC_BEQ, `OPC_BNE:
			begin
				insn_o.mode = AM_REL8;
				insn_o.is_branch = 1'b1;
				if (opcode_i == `OPC_BEQ)
					insn_o.cond = BR_EQ;
				else if (opcode_i == `OPC_BNE)
					insn_o.cond = BR_NE;
			end
			default: ;
		endcase
	end

endmodule

// ==== verilog/register_file.sv ====
// register file
// accumulators A and B, condition codes and program counter,
// written by single-cycle strobes from the sequencer

`timescale 1ns/1ps

`include "cpu_cfg.svh"

module register_file (
	input  logic                   cpu_clk,
	input  logic                   k_reset,
	input  logic                   use_b_i,
	input  logic                   acc_write_i,
	input  logic [`CPU_DATA_W-1:0] acc_data_i,
	input  logic                   flags_write_i,
	input  cpu_pkg::cc_flags_t     cc_data_i,
	input  logic                   pc_inc_i,
	input  logic                   pc_load_i,
	input  logic [`CPU_ADDR_W-1:0] pc_target_i,
	output logic [`CPU_DATA_W-1:0] acc_o,
	output logic [`CPU_ADDR_W-1:0] pc_o,
	output cpu_pkg::cc_flags_t     cc_o
);
	import cpu_pkg::*;

	logic [`CPU_DATA_W-1:0] acc_a;
	logic [`CPU_DATA_W-1:0] acc_b;
	logic [`CPU_ADDR_W-1:0] pc_q;
	cc_flags_t              cc_q;

	always_ff @(posedge cpu_clk or posedge k_reset)
	begin
		if (k_reset)
		begin
			acc_a <= '0;
			acc_b <= '0;
		end
		else if (acc_write_i)
		begin
			if (use_b_i)
				acc_b <= acc_data_i;
			else
				acc_a <= acc_data_i;
		end
	end

	always_ff @(posedge cpu_clk or posedge k_reset)
	begin
		if (k_reset)
			cc_q <= '0;
		else if (flags_write_i)
			cc_q <= cc_data_i;
	end

	always_ff @(posedge cpu_clk or posedge k_reset)
	begin
		if (k_reset)
			pc_q <= '0;
		else if (pc_load_i)
			pc_q <= pc_target_i; // load wins over increment
		else if (pc_inc_i)
			pc_q <= pc_q + 1'b1;
	end

	assign acc_o = use_b_i ? acc_b : acc_a;
	assign pc_o = pc_q;
	assign cc_o = cc_q;

endmodule
